// File: hdl/dataplane_pkg.sv
package dataplane_pkg;

	////////////////////
	// Sizes
	////////////////////

	// Flow table depth
	localparam int TCAM_ADDR_WIDTH = 3;
	localparam int TCAM_SIZE = 1 << TCAM_ADDR_WIDTH;

	// Per-packet tag, wraps at 32
	localparam int FLOW_TAG_WIDTH = 5;

	localparam int COUNTER_WIDTH = 32;
	localparam int PORT_WIDTH = 8;

	// Egress port after a VLAN rewrite
	localparam logic [PORT_WIDTH-1:0] DEFAULT_PORT = '0;

	// Accept edge to registered output
	localparam int PIPE_LATENCY = 4;

	////////////////////
	// Packet and key
	////////////////////

	// Parsed header word, 228 bits
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [15:0] ether_type;
		logic [11:0] vlan_id;
		logic [7:0]  ip_proto;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] tcp_src;
		logic [15:0] tcp_dst;
	} pkt_header_t;

	// Lookup key, 84 bits
	typedef struct packed {
		logic [15:0] ether_type;
		logic [11:0] vlan_id;
		logic [7:0]  ip_proto;
		logic [31:0] dst_ip;
		logic [15:0] tcp_dst;
	} match_key_t;

	typedef struct packed {
		logic                      valid;
		pkt_header_t               header;
		logic [FLOW_TAG_WIDTH-1:0] tag;
	} pipe_pkt_t;

	////////////////////
	// Actions
	////////////////////

	// fwd is the plain output action
	typedef struct packed {
		logic fwd;
		logic set_vlan;
		logic drop;
	} action_flags_t;

	// Argument word, read as a port or as a VLAN tag depending on the flags
	typedef union packed {
		struct packed {
			logic [7:0]            rsvd;
			logic [PORT_WIDTH-1:0] port;
		} port;
		struct packed {
			logic [2:0]  pcp;
			logic        cfi;
			logic [11:0] vid;
		} vlan;
	} action_arg_u;

	typedef struct packed {
		action_flags_t flags;
		action_arg_u   arg;
	} action_entry_t;

	////////////////////
	// Table programming
	////////////////////

	// Mask bit set means the key bit must match
	typedef struct packed {
		logic                       en;
		logic                       del;
		logic [TCAM_ADDR_WIDTH-1:0] addr;
		match_key_t                 value;
		match_key_t                 mask;
	} tcam_prog_t;

	typedef struct packed {
		logic                       en;
		logic                       del;
		logic [TCAM_ADDR_WIDTH-1:0] addr;
		action_entry_t              entry;
	} action_prog_t;

	////////////////////
	// Results
	////////////////////

	typedef struct packed {
		logic                       hit;
		logic [TCAM_ADDR_WIDTH-1:0] index;
	} lookup_t;

	typedef struct packed {
		logic                       valid;
		logic [TCAM_ADDR_WIDTH-1:0] addr;
		logic [COUNTER_WIDTH-1:0]   count;
	} meter_report_t;

endpackage

// File: hdl/header_classifier.sv
`timescale 1ns/1ns

module header_classifier (
	input  logic                      clk,
	input  logic                      rst_n,
	input  dataplane_pkg::pkt_header_t pkt_header_in,
	input  logic                      pkt_header_ready,
	input  logic                      pkt_header_accept,
	output dataplane_pkg::pipe_pkt_t  pkt_stage,
	output dataplane_pkg::match_key_t key
);

	// Header handshake completes on this edge
	logic take;

	// Tag for the next accepted packet
	logic [dataplane_pkg::FLOW_TAG_WIDTH-1:0] tag_cnt;

	dataplane_pkg::match_key_t key_next;

	assign take = pkt_header_ready & pkt_header_accept;

	// Key fields straight out of the parsed header
	always_comb begin
		key_next.ether_type = pkt_header_in.ether_type;
		key_next.vlan_id    = pkt_header_in.vlan_id;
		key_next.ip_proto   = pkt_header_in.ip_proto;
		key_next.dst_ip     = pkt_header_in.dst_ip;
		key_next.tcp_dst    = pkt_header_in.tcp_dst;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tag_cnt <= '0;
		end else if (take) begin
			tag_cnt <= tag_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_stage.valid <= 1'b0;
		end else begin
			pkt_stage.valid <= take;
		end
		if (take) begin
			pkt_stage.header <= pkt_header_in;
			pkt_stage.tag    <= tag_cnt;
		end
	end

	// Key lines up with the registered packet
	always_ff @(posedge clk) begin
		if (take) begin
			key <= key_next;
		end
	end

endmodule

// File: hdl/flow_tcam.sv
`timescale 1ns/1ns

module flow_tcam (
	input  logic                      clk,
	input  logic                      rst_n,
	input  dataplane_pkg::tcam_prog_t prog,
	input  dataplane_pkg::pipe_pkt_t  pkt_in,
	input  dataplane_pkg::match_key_t key,
	output dataplane_pkg::pipe_pkt_t  pkt_stage,
	output dataplane_pkg::lookup_t    lookup
);

	////////////////////
	// Entry storage
	////////////////////

	dataplane_pkg::match_key_t entry_value [dataplane_pkg::TCAM_SIZE];
	dataplane_pkg::match_key_t entry_mask  [dataplane_pkg::TCAM_SIZE];
	logic [dataplane_pkg::TCAM_SIZE-1:0] entry_valid;

	// One bit per entry that matches the current key
	logic [dataplane_pkg::TCAM_SIZE-1:0] match_vec;
	logic [dataplane_pkg::TCAM_ADDR_WIDTH-1:0] first_idx;

	dataplane_pkg::lookup_t lookup_next;

	// Delete has priority over a write to the same slot
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			entry_valid <= '0;
		end else if (prog.del) begin
			entry_valid[prog.addr] <= 1'b0;
		end else if (prog.en) begin
			entry_valid[prog.addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (prog.en && !prog.del) begin
			entry_value[prog.addr] <= prog.value;
			entry_mask[prog.addr]  <= prog.mask;
		end
	end

	////////////////////
	// Lookup
	////////////////////

	// Masked compare against every entry in parallel
	always_comb begin
		for (int i = 0; i < dataplane_pkg::TCAM_SIZE; i++) begin
			match_vec[i] = entry_valid[i] &&
				(((entry_value[i] ^ key) & entry_mask[i]) == '0);
		end
	end

	// Walk down so the lowest matching index is the last one written
	always_comb begin
		first_idx = '0;
		for (int i = dataplane_pkg::TCAM_SIZE - 1; i >= 0; i--) begin
			if (match_vec[i]) begin
				first_idx = i[dataplane_pkg::TCAM_ADDR_WIDTH-1:0];
			end
		end
	end

	assign lookup_next.hit   = |match_vec;
	assign lookup_next.index = first_idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_stage.valid <= 1'b0;
			lookup          <= '0;
		end else begin
			pkt_stage.valid <= pkt_in.valid;
			lookup          <= lookup_next;
		end
		pkt_stage.header <= pkt_in.header;
		pkt_stage.tag    <= pkt_in.tag;
	end

endmodule

// File: hdl/action_fetch.sv
`timescale 1ns/1ns

module action_fetch (
	input  logic                         clk,
	input  logic                         rst_n,
	input  dataplane_pkg::action_prog_t  prog,
	input  dataplane_pkg::pipe_pkt_t     pkt_in,
	input  dataplane_pkg::lookup_t       lookup_in,
	output dataplane_pkg::pipe_pkt_t     pkt_stage,
	output dataplane_pkg::lookup_t       lookup_out,
	output dataplane_pkg::action_entry_t action
);

	// One action per TCAM slot
	dataplane_pkg::action_entry_t action_table [dataplane_pkg::TCAM_SIZE];

	////////////////////
	// Table update
	////////////////////

	// Empty slot reads back with all flags low, so it acts as a drop
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < dataplane_pkg::TCAM_SIZE; i++) begin
				action_table[i] <= '0;
			end
		end else if (prog.del) begin
			action_table[prog.addr] <= '0;
		end else if (prog.en) begin
			action_table[prog.addr] <= prog.entry;
		end
	end

	////////////////////
	// Fetch stage
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_stage.valid <= 1'b0;
			lookup_out      <= '0;
		end else begin
			pkt_stage.valid <= pkt_in.valid;
			lookup_out      <= lookup_in;
		end
		pkt_stage.header <= pkt_in.header;
		pkt_stage.tag    <= pkt_in.tag;
		// A miss carries no action
		if (lookup_in.hit) begin
			action <= action_table[lookup_in.index];
		end else begin
			action <= '0;
		end
	end

endmodule

// File: hdl/flow_meter.sv
`timescale 1ns/1ns

module flow_meter (
	input  logic                          clk,
	input  logic                          rst_n,
	input  dataplane_pkg::tcam_prog_t     tcam_prog,
	input  logic                          valid,
	input  dataplane_pkg::lookup_t        lookup,
	output dataplane_pkg::meter_report_t  report
);

	logic [dataplane_pkg::COUNTER_WIDTH-1:0] counters [dataplane_pkg::TCAM_SIZE];

	// Counter value after this hit
	logic [dataplane_pkg::COUNTER_WIDTH-1:0] next_count;

	logic count_hit;

	assign count_hit  = valid & lookup.hit;
	assign next_count = counters[lookup.index] + 1'b1;

	// Reprogramming a slot starts its count again
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < dataplane_pkg::TCAM_SIZE; i++) begin
				counters[i] <= '0;
			end
		end else if (tcam_prog.en || tcam_prog.del) begin
			counters[tcam_prog.addr] <= '0;
		end else if (count_hit) begin
			counters[lookup.index] <= next_count;
		end
	end

	// Report lands in the same cycle as the fetched action
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			report.valid <= 1'b0;
		end else begin
			report.valid <= count_hit;
		end
		if (count_hit) begin
			report.addr  <= lookup.index;
			report.count <= next_count;
		end
	end

endmodule

// File: hdl/action_executor.sv
`timescale 1ns/1ns

module action_executor (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  dataplane_pkg::pipe_pkt_t              pkt_in,
	input  dataplane_pkg::lookup_t                lookup,
	input  dataplane_pkg::action_entry_t          action,
	output dataplane_pkg::pipe_pkt_t              pkt_out,
	output logic [dataplane_pkg::PORT_WIDTH-1:0]  pkt_out_port,
	output dataplane_pkg::pipe_pkt_t              miss_out
);

	logic hit;
	logic miss;
	logic discard;
	logic send;

	dataplane_pkg::pkt_header_t             header_next;
	logic [dataplane_pkg::PORT_WIDTH-1:0]   port_next;

	assign hit  = pkt_in.valid & lookup.hit;
	assign miss = pkt_in.valid & ~lookup.hit;

	// Drop wins, and an entry with no flag behaves the same
	assign discard = action.flags.drop | (action.flags == '0);
	assign send    = hit & ~discard;

	// VLAN rewrite ahead of plain output
	always_comb begin
		header_next = pkt_in.header;
		if (action.flags.set_vlan) begin
			header_next.vlan_id = action.arg.vlan.vid;
			port_next           = dataplane_pkg::DEFAULT_PORT;
		end else begin
			port_next = action.arg.port.port;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_out.valid  <= 1'b0;
			miss_out.valid <= 1'b0;
		end else begin
			pkt_out.valid  <= send;
			miss_out.valid <= miss;
		end
		pkt_out.header  <= header_next;
		pkt_out.tag     <= pkt_in.tag;
		pkt_out_port    <= port_next;
		// Controller copy goes out untouched
		miss_out.header <= pkt_in.header;
		miss_out.tag    <= pkt_in.tag;
	end

endmodule

// File: hdl/dataplane_core.sv
`timescale 1ns/1ns

module dataplane_core (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  dataplane_pkg::pkt_header_t           pkt_header_in,
	input  logic                                 pkt_header_ready,
	output logic                                 pkt_header_accept,
	input  dataplane_pkg::tcam_prog_t            tcam_prog,
	input  dataplane_pkg::action_prog_t          action_prog,
	output dataplane_pkg::pipe_pkt_t             pkt_out,
	output logic [dataplane_pkg::PORT_WIDTH-1:0] pkt_out_port,
	output dataplane_pkg::pipe_pkt_t             miss_out,
	output dataplane_pkg::meter_report_t         flow_count
);

	////////////////////
	// Stage signals
	////////////////////

	dataplane_pkg::pipe_pkt_t      cls_pkt;
	dataplane_pkg::match_key_t     cls_key;
	dataplane_pkg::pipe_pkt_t      tcam_pkt;
	dataplane_pkg::lookup_t        tcam_lookup;
	dataplane_pkg::pipe_pkt_t      fetch_pkt;
	dataplane_pkg::lookup_t        fetch_lookup;
	dataplane_pkg::action_entry_t  fetch_action;

	// Hold off new headers while either table takes a command
	assign pkt_header_accept = ~(tcam_prog.en | tcam_prog.del |
		action_prog.en | action_prog.del);

	header_classifier u_classifier (
		.clk               (clk),
		.rst_n             (rst_n),
		.pkt_header_in     (pkt_header_in),
		.pkt_header_ready  (pkt_header_ready),
		.pkt_header_accept (pkt_header_accept),
		.pkt_stage         (cls_pkt),
		.key               (cls_key)
	);

	flow_tcam u_tcam (
		.clk       (clk),
		.rst_n     (rst_n),
		.prog      (tcam_prog),
		.pkt_in    (cls_pkt),
		.key       (cls_key),
		.pkt_stage (tcam_pkt),
		.lookup    (tcam_lookup)
	);

	action_fetch u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.prog       (action_prog),
		.pkt_in     (tcam_pkt),
		.lookup_in  (tcam_lookup),
		.pkt_stage  (fetch_pkt),
		.lookup_out (fetch_lookup),
		.action     (fetch_action)
	);

	// Counts off the TCAM result, alongside the fetch stage
	flow_meter u_meter (
		.clk       (clk),
		.rst_n     (rst_n),
		.tcam_prog (tcam_prog),
		.valid     (tcam_pkt.valid),
		.lookup    (tcam_lookup),
		.report    (flow_count)
	);

	action_executor u_executor (
		.clk          (clk),
		.rst_n        (rst_n),
		.pkt_in       (fetch_pkt),
		.lookup       (fetch_lookup),
		.action       (fetch_action),
		.pkt_out      (pkt_out),
		.pkt_out_port (pkt_out_port),
		.miss_out     (miss_out)
	);

endmodule

// File: bench/dataplane_checker.sv
`timescale 1ns/1ns

module dataplane_checker (
	input logic                         clk,
	input logic                         rst_n,
	input logic                         pkt_header_ready,
	input logic                         pkt_header_accept,
	input dataplane_pkg::tcam_prog_t    tcam_prog,
	input dataplane_pkg::action_prog_t  action_prog,
	input dataplane_pkg::pipe_pkt_t     pkt_out,
	input dataplane_pkg::pipe_pkt_t     miss_out,
	input dataplane_pkg::meter_report_t flow_count
);

	// Header handshake on this edge
	logic take;
	logic prog_busy;

	// Reset was low on the previous edge
	logic in_reset;

	assign take      = pkt_header_ready & pkt_header_accept;
	assign prog_busy = tcam_prog.en | tcam_prog.del | action_prog.en | action_prog.del;

	always_ff @(posedge clk) begin
		in_reset <= !rst_n;
	end

	////////////////////
	// Output protocol
	////////////////////

	// A packet either goes out or goes to the controller
	output_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pkt_out.valid && miss_out.valid))
		else $error("pkt_out and miss_out are valid in the same cycle");

	fwd_latency: assert property (@(posedge clk) disable iff (!rst_n)
		pkt_out.valid |-> $past(take, dataplane_pkg::PIPE_LATENCY))
		else $error("pkt_out valid without an accepted header at the pipeline latency");

	miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
		miss_out.valid |-> $past(take, dataplane_pkg::PIPE_LATENCY))
		else $error("miss_out valid without an accepted header at the pipeline latency");

	// Meter report comes one stage early
	meter_latency: assert property (@(posedge clk) disable iff (!rst_n)
		flow_count.valid |-> $past(take, dataplane_pkg::PIPE_LATENCY - 1))
		else $error("flow_count valid without a matching accepted header");

	////////////////////
	// Input and reset
	////////////////////

	accept_gated: assert property (@(posedge clk)
		prog_busy |-> !pkt_header_accept)
		else $error("header accept is high during a table command");

	reset_quiet: assert property (@(posedge clk)
		in_reset |-> !(pkt_out.valid || miss_out.valid || flow_count.valid))
		else $error("an output valid is high while reset is applied");

endmodule

// File: bench/dataplane_tb.sv
`timescale 1ns/1ns

module dataplane_tb;

	localparam int CLK_HALF = 20;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 10;
	localparam int SLACK_CYCLES = 50;

	logic                                 clk = 1'b0;
	logic                                 rst_n;
	dataplane_pkg::pkt_header_t           pkt_header_in;
	logic                                 pkt_header_ready;
	logic                                 pkt_header_accept;
	dataplane_pkg::tcam_prog_t            tcam_prog;
	dataplane_pkg::action_prog_t          action_prog;
	dataplane_pkg::pipe_pkt_t             pkt_out;
	logic [dataplane_pkg::PORT_WIDTH-1:0] pkt_out_port;
	dataplane_pkg::pipe_pkt_t             miss_out;
	dataplane_pkg::meter_report_t         flow_count;

	// Shadow copy of the programmed tables
	dataplane_pkg::match_key_t                tcam_val [dataplane_pkg::TCAM_SIZE];
	dataplane_pkg::match_key_t                tcam_msk [dataplane_pkg::TCAM_SIZE];
	logic                                     tcam_vld [dataplane_pkg::TCAM_SIZE];
	dataplane_pkg::action_entry_t             act_tbl  [dataplane_pkg::TCAM_SIZE];
	logic [dataplane_pkg::COUNTER_WIDTH-1:0]  hit_cnt  [dataplane_pkg::TCAM_SIZE];
	logic [dataplane_pkg::FLOW_TAG_WIDTH-1:0] next_tag;

	// Outputs still owed by the DUT, oldest first
	dataplane_pkg::pipe_pkt_t             out_q   [$];
	logic [dataplane_pkg::PORT_WIDTH-1:0] port_q  [$];
	dataplane_pkg::pipe_pkt_t             miss_q  [$];
	dataplane_pkg::meter_report_t         meter_q [$];

	string test_name = "reset";
	int    errors = 0;
	int    tests_run = 0;
	int    tests_bad = 0;
	int    test_start_errors = 0;
	time   deadline = time'((RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);

	always #CLK_HALF clk = ~clk;

	dataplane_core DUT (
		.clk               (clk),
		.rst_n             (rst_n),
		.pkt_header_in     (pkt_header_in),
		.pkt_header_ready  (pkt_header_ready),
		.pkt_header_accept (pkt_header_accept),
		.tcam_prog         (tcam_prog),
		.action_prog       (action_prog),
		.pkt_out           (pkt_out),
		.pkt_out_port      (pkt_out_port),
		.miss_out          (miss_out),
		.flow_count        (flow_count)
	);

	bind dataplane_core dataplane_checker u_checker (
		.clk               (clk),
		.rst_n             (rst_n),
		.pkt_header_ready  (pkt_header_ready),
		.pkt_header_accept (pkt_header_accept),
		.tcam_prog         (tcam_prog),
		.action_prog       (action_prog),
		.pkt_out           (pkt_out),
		.miss_out          (miss_out),
		.flow_count        (flow_count)
	);

	////////////////////
	// Reference model
	////////////////////

	function automatic dataplane_pkg::match_key_t key_of(dataplane_pkg::pkt_header_t h);
		dataplane_pkg::match_key_t k;
		k.ether_type = h.ether_type;
		k.vlan_id    = h.vlan_id;
		k.ip_proto   = h.ip_proto;
		k.dst_ip     = h.dst_ip;
		k.tcp_dst    = h.tcp_dst;
		return k;
	endfunction

	function automatic dataplane_pkg::pkt_header_t with_key(dataplane_pkg::pkt_header_t h,
		dataplane_pkg::match_key_t k);
		h.ether_type = k.ether_type;
		h.vlan_id    = k.vlan_id;
		h.ip_proto   = k.ip_proto;
		h.dst_ip     = k.dst_ip;
		h.tcp_dst    = k.tcp_dst;
		return h;
	endfunction

	// Lowest valid entry whose cared-for bits agree, or -1
	function automatic int find_entry(dataplane_pkg::match_key_t k);
		for (int i = 0; i < dataplane_pkg::TCAM_SIZE; i++) begin
			if (tcam_vld[i] && ((k & tcam_msk[i]) == (tcam_val[i] & tcam_msk[i]))) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic void predict(dataplane_pkg::pkt_header_t h);
		dataplane_pkg::pipe_pkt_t      p;
		dataplane_pkg::action_entry_t  a;
		dataplane_pkg::meter_report_t  m;
		int                            idx;
		p.valid  = 1'b1;
		p.header = h;
		p.tag    = next_tag;
		next_tag = next_tag + 5'd1;
		idx = find_entry(key_of(h));
		if (idx < 0) begin
			miss_q.push_back(p);
			return;
		end
		hit_cnt[idx] = hit_cnt[idx] + 32'd1;
		m.valid = 1'b1;
		m.addr  = idx[dataplane_pkg::TCAM_ADDR_WIDTH-1:0];
		m.count = hit_cnt[idx];
		meter_q.push_back(m);
		a = act_tbl[idx];
		// Drop, or an entry without flags, leaves nothing on the outputs
		if (a.flags.drop || a.flags == '0) begin
			return;
		end
		if (a.flags.set_vlan) begin
			p.header.vlan_id = a.arg.vlan.vid;
			port_q.push_back(dataplane_pkg::DEFAULT_PORT);
		end else begin
			port_q.push_back(a.arg.port.port);
		end
		out_q.push_back(p);
	endfunction

	function automatic dataplane_pkg::pkt_header_t random_header();
		dataplane_pkg::pkt_header_t h;
		h = 228'({$urandom(), $urandom(), $urandom(), $urandom(),
			$urandom(), $urandom(), $urandom(), $urandom()});
		return h;
	endfunction

	// Flags are output, set_vlan, drop from the top
	function automatic dataplane_pkg::action_entry_t make_action(logic [2:0] flags,
		logic [15:0] arg);
		dataplane_pkg::action_entry_t e;
		e = {flags, arg};
		return e;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic issue_prog(dataplane_pkg::tcam_prog_t t, dataplane_pkg::action_prog_t a);
		@(posedge clk);
		tcam_prog   <= t;
		action_prog <= a;
		@(negedge clk);
		assert (!pkt_header_accept) else begin
			$display("Accept stayed high during a table command in test %s", test_name);
			errors++;
		end
		@(posedge clk);
		tcam_prog   <= '0;
		action_prog <= '0;
	endtask

	task automatic write_tcam(logic [dataplane_pkg::TCAM_ADDR_WIDTH-1:0] addr,
		dataplane_pkg::match_key_t value, dataplane_pkg::match_key_t mask);
		dataplane_pkg::tcam_prog_t t;
		t       = '0;
		t.en    = 1'b1;
		t.addr  = addr;
		t.value = value;
		t.mask  = mask;
		tcam_val[addr] = value;
		tcam_msk[addr] = mask;
		tcam_vld[addr] = 1'b1;
		hit_cnt[addr]  = '0;
		issue_prog(t, '0);
	endtask

	task automatic delete_tcam(logic [dataplane_pkg::TCAM_ADDR_WIDTH-1:0] addr);
		dataplane_pkg::tcam_prog_t t;
		t      = '0;
		t.del  = 1'b1;
		t.addr = addr;
		tcam_vld[addr] = 1'b0;
		hit_cnt[addr]  = '0;
		issue_prog(t, '0);
	endtask

	task automatic write_action(logic [dataplane_pkg::TCAM_ADDR_WIDTH-1:0] addr,
		dataplane_pkg::action_entry_t entry);
		dataplane_pkg::action_prog_t a;
		a       = '0;
		a.en    = 1'b1;
		a.addr  = addr;
		a.entry = entry;
		act_tbl[addr] = entry;
		issue_prog('0, a);
	endtask

	// Taken on the next edge, since no table command is pending
	task automatic send_packet(dataplane_pkg::pkt_header_t h);
		@(posedge clk);
		pkt_header_in    <= h;
		pkt_header_ready <= 1'b1;
		predict(h);
	endtask

	task automatic stop_packets();
		@(posedge clk);
		pkt_header_ready <= 1'b0;
	endtask

	task automatic start_test(string name, int n_packets);
		test_name = name;
		test_start_errors = errors;
		deadline = $time + time'((n_packets + SLACK_CYCLES) * CLK_PERIOD);
	endtask

	task automatic finish_test();
		while (out_q.size() + miss_q.size() + meter_q.size() != 0) begin
			@(posedge clk);
		end
		// Room for a stray output from a dropped packet
		repeat (dataplane_pkg::PIPE_LATENCY + 1) @(posedge clk);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("%s: ok", test_name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", test_name, errors - test_start_errors);
		end
	endtask

	task automatic report_mismatch(string what, logic [255:0] expected, logic [255:0] actual);
		$display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
		errors++;
	endtask

	////////////////////
	// Output monitor
	////////////////////

	always @(negedge clk) begin : watch_outputs
		dataplane_pkg::pipe_pkt_t             exp_pkt;
		dataplane_pkg::meter_report_t         exp_meter;
		logic [dataplane_pkg::PORT_WIDTH-1:0] exp_port;
		if (rst_n && pkt_out.valid) begin
			if (out_q.size() == 0) begin
				$display("Unexpected packet on pkt_out with tag %0d in test %s",
					pkt_out.tag, test_name);
				errors++;
			end else begin
				exp_pkt  = out_q.pop_front();
				exp_port = port_q.pop_front();
				assert (pkt_out == exp_pkt)
					else report_mismatch("pkt_out", 256'(exp_pkt), 256'(pkt_out));
				assert (pkt_out_port == exp_port)
					else report_mismatch("pkt_out_port", 256'(exp_port), 256'(pkt_out_port));
			end
		end
		if (rst_n && miss_out.valid) begin
			if (miss_q.size() == 0) begin
				$display("Unexpected packet on miss_out with tag %0d in test %s",
					miss_out.tag, test_name);
				errors++;
			end else begin
				exp_pkt = miss_q.pop_front();
				assert (miss_out == exp_pkt)
					else report_mismatch("miss_out", 256'(exp_pkt), 256'(miss_out));
			end
		end
		if (rst_n && flow_count.valid) begin
			if (meter_q.size() == 0) begin
				$display("Unexpected meter report for entry %0d in test %s",
					flow_count.addr, test_name);
				errors++;
			end else begin
				exp_meter = meter_q.pop_front();
				assert (flow_count == exp_meter)
					else report_mismatch("flow_count", 256'(exp_meter), 256'(flow_count));
			end
		end
	end

	initial begin : watchdog
		while ($time <= deadline) begin
			@(posedge clk);
		end
		$display("Timeout in test %s with %0d outputs still missing", test_name,
			out_q.size() + miss_q.size() + meter_q.size());
		$display("test failed");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin : main
		dataplane_pkg::pkt_header_t h;
		dataplane_pkg::match_key_t  key_a;
		dataplane_pkg::match_key_t  key_b;
		dataplane_pkg::match_key_t  key_c;
		dataplane_pkg::match_key_t  key_d;
		dataplane_pkg::match_key_t  k;
		dataplane_pkg::match_key_t  m;
		void'($urandom(32'hd5039c2b));
		rst_n            <= 1'b0;
		pkt_header_in    <= '0;
		pkt_header_ready <= 1'b0;
		tcam_prog        <= '0;
		action_prog      <= '0;
		next_tag = '0;
		for (int i = 0; i < dataplane_pkg::TCAM_SIZE; i++) begin
			tcam_val[i] = '0;
			tcam_msk[i] = '0;
			tcam_vld[i] = 1'b0;
			act_tbl[i]  = '0;
			hit_cnt[i]  = '0;
		end

		start_test("reset", RESET_CYCLES);
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (pkt_header_accept && !pkt_out.valid && !miss_out.valid && !flow_count.valid)
		else begin
			$display("Outputs not idle or accept low right after reset");
			errors++;
		end
		finish_test();

		// Exact key, plain output, back to back
		start_test("exact_fwd", 8);
		key_a = key_of(random_header());
		write_tcam(0, key_a, '1);
		write_action(0, make_action(3'b100, 16'h0011));
		for (int i = 0; i < 8; i++) begin
			send_packet(with_key(random_header(), key_a));
		end
		stop_packets();
		finish_test();

		// Entry 1 sits inside entry 2
		start_test("priority", 8);
		m = '0;
		k = '0;
		m.ether_type = '1;
		m.dst_ip     = 32'hff00_0000;
		k.ether_type = 16'h0800;
		k.dst_ip     = 32'h0a00_0000;
		write_tcam(2, k, m);
		write_action(2, make_action(3'b100, 16'h0022));
		m.dst_ip = 32'hffff_0000;
		k.dst_ip = 32'h0a01_0000;
		write_tcam(1, k, m);
		write_action(1, make_action(3'b100, 16'h0033));
		for (int i = 0; i < 8; i++) begin
			h = random_header();
			h.ether_type = 16'h0800;
			h.dst_ip     = {8'h0a, i[0] ? 8'h01 : 8'h02, 16'($urandom())};
			send_packet(h);
		end
		stop_packets();
		finish_test();

		start_test("vlan_drop", 9);
		key_b = key_of(random_header());
		key_c = key_of(random_header());
		key_d = key_of(random_header());
		write_tcam(3, key_b, '1);
		write_action(3, make_action(3'b110, {3'd5, 1'b1, 12'h5a5}));
		write_tcam(4, key_c, '1);
		write_action(4, make_action(3'b001, 16'h00ff));
		// Slot 5 has no action written
		write_tcam(5, key_d, '1);
		for (int i = 0; i < 9; i++) begin
			case (i % 3)
				0: k = key_b;
				1: k = key_c;
				default: k = key_d;
			endcase
			send_packet(with_key(random_header(), k));
		end
		stop_packets();
		finish_test();

		start_test("miss", 6);
		delete_tcam(0);
		for (int i = 0; i < 6; i++) begin
			h = with_key(random_header(), key_a);
			if (i[0]) begin
				h.ether_type = 16'h86dd;
			end
			send_packet(h);
		end
		stop_packets();
		finish_test();

		// Rewriting slot 3 restarts its count
		start_test("recount", 4);
		write_tcam(3, key_b, '1);
		for (int i = 0; i < 4; i++) begin
			send_packet(with_key(random_header(), key_b));
		end
		stop_packets();
		finish_test();

		$display("%0d tests, %0d with errors, %0d errors in total",
			tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: netwalk_dataplane.f
hdl/dataplane_pkg.sv
hdl/header_classifier.sv
hdl/flow_tcam.sv
hdl/action_fetch.sv
hdl/flow_meter.sv
hdl/action_executor.sv
hdl/dataplane_core.sv
bench/dataplane_checker.sv
bench/dataplane_tb.sv

// File: run.sh
#!/bin/sh
# Build the simulation, run it, and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module dataplane_tb \
	-f netwalk_dataplane.f -Mdir obj_dir &&
./obj_dir/Vdataplane_tb | tee /dev/stderr | grep -q "^test passed$" &&
echo "simulation ok" ||
{ echo "simulation did not pass" >&2; exit 1; }
